// File: verilog/rv_isa_pkg.sv
package rv_isa_pkg;

  //////////////////////////////
  // Widths
  //////////////////////////////

  localparam int unsigned xlen    = 32;
  localparam int unsigned nreg    = 32;
  localparam int unsigned reg_aw  = $clog2(nreg);
  localparam int unsigned shamt_w = $clog2(xlen);

  localparam logic [xlen-1:0] reset_pc = 32'h0000_0000;

  //////////////////////////////
  // Encodings
  //////////////////////////////

  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_op_imm = 7'b0010011;
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_system = 7'b1110011;

  // funct3 shared by OP and OP-IMM
  localparam logic [2:0] f3_add  = 3'b000;
  localparam logic [2:0] f3_sll  = 3'b001;
  localparam logic [2:0] f3_slt  = 3'b010;
  localparam logic [2:0] f3_sltu = 3'b011;
  localparam logic [2:0] f3_xor  = 3'b100;
  localparam logic [2:0] f3_sr   = 3'b101;
  localparam logic [2:0] f3_or   = 3'b110;
  localparam logic [2:0] f3_and  = 3'b111;
  localparam logic [2:0] f3_priv = 3'b000;

  // Bit 30 set selects SUB and SRA/SRAI
  localparam logic [6:0] f7_alt = 7'b0100000;

  localparam logic [11:0] f12_ecall = 12'h000;
  localparam logic [11:0] f12_mret  = 12'h302;

  typedef struct packed {
    logic [6:0]        funct7;
    logic [reg_aw-1:0] rs2;
    logic [reg_aw-1:0] rs1;
    logic [2:0]        funct3;
    logic [reg_aw-1:0] rd;
    logic [6:0]        opcode;
  } r_view_t;

  typedef struct packed {
    logic [11:0]       imm12;
    logic [reg_aw-1:0] rs1;
    logic [2:0]        funct3;
    logic [reg_aw-1:0] rd;
    logic [6:0]        opcode;
  } i_view_t;

  // Same 32-bit word, two field layouts
  typedef union packed {
    r_view_t r;
    i_view_t i;
  } instr_t;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_and,
    alu_or,
    alu_xor,
    alu_sll,
    alu_srl,
    alu_sra,
    alu_slt,
    alu_sltu,
    alu_pass_b
  } alu_op_t;

endpackage

// File: verilog/rv_pipe_pkg.sv
package rv_pipe_pkg;

  //////////////////////////////
  // IF/ID
  //////////////////////////////

  typedef struct packed {
    logic                          valid;
    logic [rv_isa_pkg::xlen-1:0]   pc;
    rv_isa_pkg::instr_t            instr;
  } if_id_t;

  //////////////////////////////
  // ID/EX
  //////////////////////////////

  typedef struct packed {
    logic                          valid;
    logic [rv_isa_pkg::xlen-1:0]   pc;
    logic [rv_isa_pkg::reg_aw-1:0] rs1;
    logic [rv_isa_pkg::reg_aw-1:0] rs2;
    logic [rv_isa_pkg::reg_aw-1:0] rd;
    // Register values as read in decode
    logic [rv_isa_pkg::xlen-1:0]   op_a;
    logic [rv_isa_pkg::xlen-1:0]   op_b;
    logic [rv_isa_pkg::xlen-1:0]   imm;
    logic                          use_imm;
    rv_isa_pkg::alu_op_t           alu_op;
    logic                          reg_write;
    logic                          is_ecall;
    logic                          is_mret;
  } id_ex_t;

  //////////////////////////////
  // EX/WB
  //////////////////////////////

  typedef struct packed {
    logic                          valid;
    logic [rv_isa_pkg::reg_aw-1:0] rd;
    logic                          reg_write;
    logic [rv_isa_pkg::xlen-1:0]   result;
  } ex_wb_t;

endpackage

// File: verilog/rv_fetch.sv
`timescale 1ns/1ps

module rv_fetch (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic                        hold,
  input  logic                        debug,
  input  logic [rv_isa_pkg::xlen-1:0] imem_dout,
  output logic [rv_isa_pkg::xlen-1:0] imem_addr,
  output logic                        stall,
  output rv_pipe_pkg::if_id_t         if_id
);

  import rv_isa_pkg::*;

  logic [xlen-1:0] pc;
  logic [xlen-1:0] pc_q;
  instr_t          instr_q;
  logic            valid_q;

  // Single freeze level for the whole pipe
  assign stall     = hold | debug;
  assign imem_addr = pc;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc      <= reset_pc;
      valid_q <= 1'b0;
    end else if (!stall) begin
      pc      <= pc + xlen'(4);
      valid_q <= 1'b1;
    end
  end

  // Fetched word travels with its own PC
  always_ff @(posedge clk) begin
    if (!stall) begin
      pc_q    <= pc;
      instr_q <= imem_dout;
    end
  end

  always_comb begin
    if_id.valid = valid_q;
    if_id.pc    = pc_q;
    if_id.instr = instr_q;
  end

endmodule

// File: verilog/rv_decode.sv
`timescale 1ns/1ps

module rv_decode (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          stall,
  input  rv_pipe_pkg::if_id_t           if_id,
  input  logic [rv_isa_pkg::xlen-1:0]   rs1_data,
  input  logic [rv_isa_pkg::xlen-1:0]   rs2_data,
  output logic [rv_isa_pkg::reg_aw-1:0] rs1_addr,
  output logic [rv_isa_pkg::reg_aw-1:0] rs2_addr,
  output rv_pipe_pkg::id_ex_t           id_ex
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  instr_t ins;
  id_ex_t dec;
  id_ex_t id_ex_q;
  logic   valid_q;
  logic   legal;
  logic   writes;

  // ALU function from funct3, alt marks SUB or arithmetic shift
  function automatic alu_op_t alu_sel(input logic [2:0] funct3, input logic alt);
    alu_op_t op;
    op = alu_add;
    case (funct3)
      f3_add:  op = alt ? alu_sub : alu_add;
      f3_sll:  op = alu_sll;
      f3_slt:  op = alu_slt;
      f3_sltu: op = alu_sltu;
      f3_xor:  op = alu_xor;
      f3_sr:   op = alt ? alu_sra : alu_srl;
      f3_or:   op = alu_or;
      f3_and:  op = alu_and;
    endcase
    return op;
  endfunction

  assign ins      = if_id.instr;
  assign rs1_addr = ins.r.rs1;
  assign rs2_addr = ins.r.rs2;

  //////////////////////////////
  // Decode
  //////////////////////////////

  always_comb begin
    legal      = 1'b0;
    writes     = 1'b0;
    dec        = '0;
    dec.pc     = if_id.pc;
    dec.rs1    = ins.r.rs1;
    dec.rs2    = ins.r.rs2;
    dec.rd     = ins.r.rd;
    dec.op_a   = rs1_data;
    dec.op_b   = rs2_data;
    dec.alu_op = alu_add;
    // I-type immediate, sign extended
    dec.imm    = {{(xlen-12){ins.i.imm12[11]}}, ins.i.imm12};
    case (ins.r.opcode)
      op_op: begin
        legal      = 1'b1;
        writes     = 1'b1;
        dec.alu_op = alu_sel(ins.r.funct3, ins.r.funct7 == f7_alt);
      end
      op_op_imm: begin
        legal       = 1'b1;
        writes      = 1'b1;
        dec.use_imm = 1'b1;
        // Upper imm bits only mean SRAI under the shift-right funct3
        dec.alu_op  = alu_sel(ins.i.funct3,
                              ins.i.funct3 == f3_sr && ins.r.funct7 == f7_alt);
      end
      op_lui: begin
        legal       = 1'b1;
        writes      = 1'b1;
        dec.use_imm = 1'b1;
        dec.alu_op  = alu_pass_b;
        // U immediate from the upper fields of the I view
        dec.imm     = {ins.i.imm12, ins.i.rs1, ins.i.funct3, 12'h000};
      end
      op_system: begin
        legal        = ins.i.funct3 == f3_priv;
        dec.is_ecall = legal && ins.i.imm12 == f12_ecall;
        dec.is_mret  = legal && ins.i.imm12 == f12_mret;
      end
      default: begin
      end
    endcase
    // Unknown opcodes become a bubble
    dec.valid     = if_id.valid & legal;
    // x0 is never a write target
    dec.reg_write = writes & (ins.r.rd != '0);
  end

  //////////////////////////////
  // ID/EX register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= dec.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      id_ex_q <= dec;
    end
  end

  always_comb begin
    id_ex       = id_ex_q;
    id_ex.valid = valid_q;
  end

endmodule

// File: verilog/rv_regfile.sv
`timescale 1ns/1ps

module rv_regfile (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          debug,
  input  logic [rv_isa_pkg::reg_aw-1:0] debug_input,
  input  logic [rv_isa_pkg::reg_aw-1:0] rs1_addr,
  input  logic [rv_isa_pkg::reg_aw-1:0] rs2_addr,
  input  rv_pipe_pkg::ex_wb_t           ex_wb,
  input  logic                          stall,
  output logic [rv_isa_pkg::xlen-1:0]   rs1_data,
  output logic [rv_isa_pkg::xlen-1:0]   rs2_data
);

  import rv_isa_pkg::*;

  logic [xlen-1:0]   regs [nreg];
  logic [reg_aw-1:0] port1_addr;
  logic              wb_live;

  assign wb_live    = ex_wb.valid & ex_wb.reg_write;
  // Debug takes over the first read port
  assign port1_addr = debug ? debug_input : rs1_addr;

  // x0 is hardwired, pending write passes straight through
  function automatic logic [xlen-1:0] read_port(input logic [reg_aw-1:0] addr);
    logic [xlen-1:0] data;
    if (addr == '0) begin
      data = '0;
    end else if (wb_live && ex_wb.rd == addr) begin
      data = ex_wb.result;
    end else begin
      data = regs[addr];
    end
    return data;
  endfunction

  always_comb begin
    rs1_data = read_port(port1_addr);
    rs2_data = read_port(rs2_addr);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < nreg; i++) begin
        regs[i] <= '0;
      end
    end else if (wb_live && !stall) begin
      regs[ex_wb.rd] <= ex_wb.result;
    end
  end

endmodule

// File: verilog/rv_execute.sv
`timescale 1ns/1ps

module rv_execute (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                stall,
  input  rv_pipe_pkg::id_ex_t id_ex,
  output rv_pipe_pkg::ex_wb_t ex_wb,
  output logic                trapping,
  output logic                trap_pulse
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic [xlen-1:0] src_a;
  logic [xlen-1:0] rs2_val;
  logic [xlen-1:0] src_b;
  logic [xlen-1:0] alu_res;
  logic            wb_hit;
  logic            ecall_now;
  logic            mret_now;
  logic            valid_q;
  ex_wb_t          ex_wb_q;

  //////////////////////////////
  // Operands
  //////////////////////////////

  // Distance-one bypass from EX/WB
  assign wb_hit  = ex_wb.valid & ex_wb.reg_write;
  assign src_a   = (wb_hit && ex_wb.rd == id_ex.rs1) ? ex_wb.result : id_ex.op_a;
  assign rs2_val = (wb_hit && ex_wb.rd == id_ex.rs2) ? ex_wb.result : id_ex.op_b;
  assign src_b   = id_ex.use_imm ? id_ex.imm : rs2_val;

  always_comb begin
    case (id_ex.alu_op)
      alu_add:  alu_res = src_a + src_b;
      alu_sub:  alu_res = src_a - src_b;
      alu_and:  alu_res = src_a & src_b;
      alu_or:   alu_res = src_a | src_b;
      alu_xor:  alu_res = src_a ^ src_b;
      alu_sll:  alu_res = src_a << src_b[shamt_w-1:0];
      alu_srl:  alu_res = src_a >> src_b[shamt_w-1:0];
      alu_sra:  alu_res = $signed(src_a) >>> src_b[shamt_w-1:0];
      alu_slt:  alu_res = {{(xlen-1){1'b0}}, $signed(src_a) < $signed(src_b)};
      alu_sltu: alu_res = {{(xlen-1){1'b0}}, src_a < src_b};
      // LUI passes the immediate
      default:  alu_res = src_b;
    endcase
  end

  //////////////////////////////
  // EX/WB register
  //////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else if (!stall) begin
      valid_q <= id_ex.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (!stall) begin
      ex_wb_q.valid     <= id_ex.valid;
      ex_wb_q.rd        <= id_ex.rd;
      ex_wb_q.reg_write <= id_ex.reg_write;
      ex_wb_q.result    <= alu_res;
    end
  end

  always_comb begin
    ex_wb       = ex_wb_q;
    ex_wb.valid = valid_q;
  end

  // Trap status, evaluated only as the instruction leaves ID/EX
  assign ecall_now = id_ex.valid & id_ex.is_ecall;
  assign mret_now  = id_ex.valid & id_ex.is_mret;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      trapping   <= 1'b0;
      trap_pulse <= 1'b0;
    end else if (stall) begin
      trap_pulse <= 1'b0;
    end else begin
      trap_pulse <= ecall_now & ~trapping;
      if (ecall_now && !trapping) begin
        trapping <= 1'b1;
      end else if (mret_now && trapping) begin
        trapping <= 1'b0;
      end
    end
  end

endmodule

// File: verilog/rv_core.sv
`timescale 1ns/1ps

module rv_core (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          hold,
  input  logic                          debug,
  input  logic [rv_isa_pkg::reg_aw-1:0] debug_input,
  input  logic [rv_isa_pkg::xlen-1:0]   imem_dout,
  output logic [rv_isa_pkg::xlen-1:0]   imem_addr,
  output logic [rv_isa_pkg::xlen-1:0]   debug_output,
  output logic                          trapping,
  output logic                          trap_pulse
);

  import rv_isa_pkg::*;
  import rv_pipe_pkg::*;

  logic              stall;
  if_id_t            if_id;
  id_ex_t            id_ex;
  ex_wb_t            ex_wb;
  logic [reg_aw-1:0] rs1_addr;
  logic [reg_aw-1:0] rs2_addr;
  logic [xlen-1:0]   rs1_data;
  logic [xlen-1:0]   rs2_data;

  //////////////////////////////
  // Stages
  //////////////////////////////

  rv_fetch u0_if (
    .clk       (clk),
    .rst_n     (rst_n),
    .hold      (hold),
    .debug     (debug),
    .imem_dout (imem_dout),
    .imem_addr (imem_addr),
    .stall     (stall),
    .if_id     (if_id)
  );

  rv_decode u1_id (
    .clk      (clk),
    .rst_n    (rst_n),
    .stall    (stall),
    .if_id    (if_id),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .id_ex    (id_ex)
  );

  rv_regfile u2_reg (
    .clk         (clk),
    .rst_n       (rst_n),
    .debug       (debug),
    .debug_input (debug_input),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .ex_wb       (ex_wb),
    .stall       (stall),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data)
  );

  rv_execute u3_ex (
    .clk        (clk),
    .rst_n      (rst_n),
    .stall      (stall),
    .id_ex      (id_ex),
    .ex_wb      (ex_wb),
    .trapping   (trapping),
    .trap_pulse (trap_pulse)
  );

  // Debug view, address 0 shows the PC held in decode
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      debug_output <= '0;
    end else if (debug) begin
      debug_output <= (debug_input == '0) ? if_id.pc : rs1_data;
    end else begin
      debug_output <= '0;
    end
  end

endmodule

// File: sim/tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  localparam int n_seed      = 4;
  localparam int n_rand_a    = 40;
  localparam int n_rand_b    = 30;
  localparam int n_fixed     = 21;
  localparam int drain       = 8;
  localparam int reset_cyc   = 3;
  localparam int hold_budget = 60;
  localparam int dbg_cycles  = 2 * 32 + 6;
  localparam int runs        = 3;
  localparam int cycle_limit = 2 * (2 * n_seed + n_rand_a + n_rand_b + n_fixed
                                    + runs * (drain + reset_cyc + dbg_cycles) + hold_budget);

  logic        clk;
  logic        rst_n;
  logic        hold;
  logic        debug;
  logic [4:0]  debug_input;
  logic [31:0] imem_dout;
  logic [31:0] imem_addr;
  logic [31:0] debug_output;
  logic        trapping;
  logic        trap_pulse;

  logic [31:0] imem [256];
  logic [31:0] model_regs [32];
  logic        model_trap;
  int          model_pulses;
  int          prog_len;
  logic [31:0] lfsr;
  int          errors;
  int          adv_edges;
  int          pulse_count;
  logic        prev_pulse;
  int          cycles;

  rv_core i_rv_core (
    .clk          (clk),
    .rst_n        (rst_n),
    .hold         (hold),
    .debug        (debug),
    .debug_input  (debug_input),
    .imem_dout    (imem_dout),
    .imem_addr    (imem_addr),
    .debug_output (debug_output),
    .trapping     (trapping),
    .trap_pulse   (trap_pulse)
  );

  // Word-addressed instruction memory
  assign imem_dout = imem[imem_addr[9:2]];

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  //////////////////////////////
  // Encoding and random helpers
  //////////////////////////////

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'h33};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, 7'h13};
  endfunction

  function automatic logic [31:0] lui_word(input logic [19:0] imm, input logic [4:0] rd);
    return {imm, rd, 7'h37};
  endfunction

  // Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
  function automatic logic [31:0] next_bits(input int n);
    logic [31:0] v;
    logic        fb;
    v = '0;
    for (int k = 0; k < n; k++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v    = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic void put_instr(input logic [31:0] ins);
    imem[prog_len] = ins;
    prog_len++;
  endfunction

  // ADDI x0 no-ops whose immediate follows the slot index
  function automatic void fill_imem();
    for (int i = 0; i < 256; i++) begin
      imem[i] = i_type(12'(i), 5'd0, 3'd0, 5'd0);
    end
    prog_len = 0;
  endfunction

  // Signed edge values in x1 to x4
  function automatic void seed_regs();
    put_instr(lui_word(20'h80000, 5'd1));
    put_instr(i_type(12'hfff, 5'd1, 3'd0, 5'd2));
    put_instr(i_type(12'hfff, 5'd0, 3'd0, 5'd3));
    put_instr(i_type(12'h001, 5'd0, 3'd0, 5'd4));
  endfunction

  function automatic void random_alu_program(input int count);
    logic [1:0]  kind;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic        alt;
    logic [11:0] imm;
    for (int k = 0; k < count; k++) begin
      kind = 2'(next_bits(2));
      rd   = 5'(next_bits(5));
      rs1  = 5'(next_bits(5));
      rs2  = 5'(next_bits(5));
      f3   = 3'(next_bits(3));
      alt  = next_bits(1) == 1;
      if (kind == 2'd3) begin
        put_instr(lui_word(20'(next_bits(20)), rd));
      end else if (kind == 2'd2) begin
        // Shifts carry shamt in the low immediate bits
        if (f3 == 3'd1) begin
          imm = {7'h00, rs2};
        end else if (f3 == 3'd5) begin
          imm = {alt ? 7'h20 : 7'h00, rs2};
        end else begin
          imm = 12'(next_bits(12));
        end
        put_instr(i_type(imm, rs1, f3, rd));
      end else begin
        put_instr(r_type(((f3 == 3'd0 || f3 == 3'd5) && alt) ? 7'h20 : 7'h00,
                         rs2, rs1, f3, rd));
      end
    end
  endfunction

  // Hazards at distances one to three plus x0 writes and traps
  function automatic void hazard_program();
    put_instr(i_type(12'd5, 5'd0, 3'd0, 5'd1));
    put_instr(i_type(12'd3, 5'd1, 3'd0, 5'd2));
    put_instr(r_type(7'h20, 5'd1, 5'd2, 3'd0, 5'd3));
    put_instr(r_type(7'h00, 5'd1, 5'd3, 3'd1, 5'd4));
    put_instr(lui_word(20'h12345, 5'd5));
    put_instr(i_type(12'h678, 5'd5, 3'd0, 5'd5));
    put_instr(r_type(7'h00, 5'd4, 5'd5, 3'd4, 5'd6));
    put_instr(i_type(12'd9, 5'd1, 3'd0, 5'd0));
    put_instr(r_type(7'h00, 5'd1, 5'd0, 3'd0, 5'd7));
    put_instr(r_type(7'h00, 5'd0, 5'd0, 3'd6, 5'd8));
    put_instr(32'h0000_0073);
    put_instr(i_type(12'd1, 5'd7, 3'd0, 5'd9));
    put_instr(32'h0000_0073);
    put_instr(32'h3020_0073);
    put_instr(32'h3020_0073);
    put_instr(32'h0000_0073);
    put_instr(lui_word(20'hf0000, 5'd11));
    put_instr(i_type({7'h20, 5'd4}, 5'd11, 3'd5, 5'd12));
    put_instr(r_type(7'h00, 5'd1, 5'd11, 3'd2, 5'd13));
    put_instr(r_type(7'h00, 5'd1, 5'd11, 3'd3, 5'd14));
    put_instr(32'h3020_0073);
  endfunction

  //////////////////////////////
  // Reference model
  //////////////////////////////

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] a, input logic [31:0] b);
    logic [31:0] r;
    case (f3)
      3'd0: r = alt ? a - b : a + b;
      3'd1: r = a << b[4:0];
      3'd2: r = {31'd0, $signed(a) < $signed(b)};
      3'd3: r = {31'd0, a < b};
      3'd4: r = a ^ b;
      3'd5: begin
        if (alt) begin
          r = $signed(a) >>> b[4:0];
        end else begin
          r = a >> b[4:0];
        end
      end
      3'd6: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  function automatic void exec_model(input logic [31:0] ins);
    logic [2:0]  f3;
    logic [4:0]  rd;
    logic [31:0] a;
    logic [31:0] res;
    logic        wr;
    f3  = ins[14:12];
    rd  = ins[11:7];
    a   = model_regs[ins[19:15]];
    res = '0;
    wr  = 1'b0;
    case (ins[6:0])
      7'h33: begin
        res = alu_model(f3, ins[30], a, model_regs[ins[24:20]]);
        wr  = 1'b1;
      end
      7'h13: begin
        res = alu_model(f3, f3 == 3'd5 && ins[30], a, {{20{ins[31]}}, ins[31:20]});
        wr  = 1'b1;
      end
      7'h37: begin
        res = {ins[31:12], 12'h000};
        wr  = 1'b1;
      end
      7'h73: begin
        if (f3 == 3'd0 && ins[31:20] == 12'h000 && !model_trap) begin
          model_trap = 1'b1;
          model_pulses++;
        end else if (f3 == 3'd0 && ins[31:20] == 12'h302 && model_trap) begin
          model_trap = 1'b0;
        end
      end
      default: begin
      end
    endcase
    if (wr && rd != 5'd0) begin
      model_regs[rd] = res;
    end
  endfunction

  function automatic void predict_program();
    for (int i = 0; i < 32; i++) begin
      model_regs[i] = '0;
    end
    model_trap   = 1'b0;
    model_pulses = 0;
    for (int i = 0; i < prog_len; i++) begin
      exec_model(imem[i]);
    end
  endfunction

  //////////////////////////////
  // Monitor
  //////////////////////////////

  // PC steps once per unstalled edge and trap_pulse lasts one cycle
  always @(negedge clk) begin
    if (rst_n !== 1'b1) begin
      adv_edges   = 0;
      pulse_count = 0;
      prev_pulse  = 1'b0;
    end else begin
      assert (imem_addr == 32'(4 * adv_edges)) else begin
        errors++;
        $display("[ERROR] %0t: imem_addr is %h, expected %h", $time, imem_addr,
                 32'(4 * adv_edges));
      end
      assert (!(trap_pulse && prev_pulse)) else begin
        errors++;
        $display("trap_pulse stayed high for more than one cycle at %0t", $time);
      end
      if (trap_pulse) begin
        pulse_count++;
      end
      prev_pulse = trap_pulse;
      if (!hold && !debug) begin
        adv_edges++;
      end
    end
  end

  //////////////////////////////
  // Stimulus
  //////////////////////////////

  task automatic run_program(input logic with_hold);
    int stretch;
    int budget;
    predict_program();
    @(posedge clk);
    rst_n <= 1'b0;
    hold  <= 1'b0;
    debug <= 1'b0;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    stretch = 0;
    budget  = hold_budget;
    while (adv_edges < prog_len + drain) begin
      @(posedge clk);
      if (stretch > 0 && budget > 0) begin
        stretch--;
        budget--;
        hold <= 1'b1;
      end else if (with_hold && budget > 0 && next_bits(2) == 0) begin
        stretch = int'(next_bits(3));
        budget--;
        hold <= 1'b1;
      end else begin
        hold <= 1'b0;
      end
    end
  endtask

  // Freeze with debug and read every register back
  task automatic check_state();
    @(posedge clk);
    hold        <= 1'b0;
    debug       <= 1'b1;
    debug_input <= 5'd0;
    @(posedge clk);
    @(negedge clk);
    assert (debug_output == 32'(4 * (adv_edges - 1))) else begin
      errors++;
      $display("[ERROR] %0t: decode PC is %h, expected %h", $time, debug_output,
               32'(4 * (adv_edges - 1)));
    end
    for (int r = 1; r < 32; r++) begin
      @(posedge clk);
      debug_input <= 5'(r);
      @(posedge clk);
      @(negedge clk);
      assert (debug_output == model_regs[r]) else begin
        errors++;
        $display("[ERROR] %0t: x%0d is %h, expected %h", $time, r, debug_output,
                 model_regs[r]);
      end
    end
    assert (trapping == model_trap && pulse_count == model_pulses) else begin
      errors++;
      $display("[ERROR] %0t: trapping %0b with %0d pulses, expected %0b with %0d", $time,
               trapping, pulse_count, model_trap, model_pulses);
    end
    @(posedge clk);
    debug <= 1'b0;
    @(posedge clk);
    @(negedge clk);
    assert (debug_output == '0) else begin
      errors++;
      $display("[ERROR] %0t: debug_output is %h with debug low", $time, debug_output);
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    hold        = 1'b0;
    debug       = 1'b0;
    debug_input = 5'd0;
    errors      = 0;
    lfsr        = 32'hcc5;
    fill_imem();
    seed_regs();
    random_alu_program(n_rand_a);
    run_program(1'b0);
    check_state();
    fill_imem();
    hazard_program();
    run_program(1'b0);
    check_state();
    fill_imem();
    seed_regs();
    random_alu_program(n_rand_b);
    run_program(1'b1);
    check_state();
    $display("Checks done, %0d errors", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("The run timed out after %0d cycles", cycles);
    $display("Something failed");
    $finish;
  end

endmodule

// File: files.f
verilog/rv_isa_pkg.sv
verilog/rv_pipe_pkg.sv
verilog/rv_fetch.sv
verilog/rv_decode.sv
verilog/rv_regfile.sv
verilog/rv_execute.sv
verilog/rv_core.sv
sim/tb_rv_core.sv

// File: Makefile
OBJ_DIR = obj_dir
LOG     = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --top-module tb_rv_core -f files.f
	verilator --lint-only --top-module rv_core verilog/rv_isa_pkg.sv verilog/rv_pipe_pkg.sv \
		verilog/rv_fetch.sv verilog/rv_decode.sv verilog/rv_regfile.sv \
		verilog/rv_execute.sv verilog/rv_core.sv

sim:
	verilator --binary --timing --assert --top-module tb_rv_core -f files.f \
		--Mdir $(OBJ_DIR) -o sim_rv_core
	./$(OBJ_DIR)/sim_rv_core | tee $(LOG)
	grep -q "^Everything OK$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
